// File: run.sh
#!/bin/sh
# build the SPI flash master testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module tbSpiFlashCtrl -Mdir obj_dir \
	|| exit 1
out=$(./obj_dir/VtbSpiFlashCtrl)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "ALL TESTS PASSED" && exit 0 || exit 1

// File: src/axiLiteSpiRegs.sv
// AXI4-Lite register block of the SPI flash master.
// A data write becomes one byte command to the engine; the status read shows busy and rx byte.
`include "spiFlash_settings.svh"

module axiLiteSpiRegs (
	input  logic                     clk,
	input  logic                     rstN,
	input  spiFlashPkg::axiLiteReq_t axiReq,
	output spiFlashPkg::axiLiteRsp_t axiRsp,
	output spiFlashPkg::spiCmd_t     cmd,
	output logic                     cmdValid,
	input  logic                     cmdReady,
	input  spiFlashPkg::spiStatus_t  status
);
	import spiFlashPkg::*;

	localparam logic [`SPI_ADDR_W-1:0] AddrData = `SPI_ADDR_W'(`SPI_REG_DATA);
	localparam logic [`SPI_ADDR_W-1:0] AddrStatus = `SPI_ADDR_W'(`SPI_REG_STATUS);

	logic        wrAccept;  // AW and W taken together
	logic        wrIsData;
	logic        rdAccept;
	spiCmd_t     lastCmd;   // readback of the data register
	logic        bvalid;
	axiResp_t    bresp;
	logic        rvalid;
	logic [31:0] rdata;
	axiResp_t    rresp;
	logic [31:0] rdWord;    // read mux output, registered into rdata
	axiResp_t    rdResp;

	// write path
	// both channels must be valid together, B must be free and the engine idle
	// error writes wait for the engine too, which keeps the write order simple
	assign wrAccept = axiReq.awvalid & axiReq.wvalid & ~bvalid & cmdReady;
	assign wrIsData = (axiReq.awaddr == AddrData);
	assign cmdValid = wrAccept & wrIsData;  // single cycle, engine goes busy right after

	// byte lanes merge into the stored command
	always_comb begin
		cmd = lastCmd;
		if (axiReq.wstrb[0]) begin
			cmd.data = axiReq.wdata[7:0];
		end
		if (axiReq.wstrb[1]) begin
			cmd.deselect = axiReq.wdata[8];  // bit 8 set means csN high, no transfer
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			lastCmd <= '{deselect: 1'b1, data: 8'h00};  // matches csN high after reset
		end else if (cmdValid) begin
			lastCmd <= cmd;
		end
	end

	// B channel, response one cycle after acceptance
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			bvalid <= 1'b0;
			bresp  <= OKAY;
		end else if (wrAccept) begin
			bvalid <= 1'b1;
			bresp  <= wrIsData ? OKAY : SLVERR;  // status is read only, others unmapped
		end else if (axiReq.bready) begin
			bvalid <= 1'b0;
		end
	end

	// read path
	assign rdAccept = axiReq.arvalid & ~rvalid;  // held R blocks the next AR

	always_comb begin
		rdWord = 32'h0;
		rdResp = OKAY;
		case (axiReq.araddr)
			AddrData: rdWord = {23'h0, lastCmd};
			AddrStatus: rdWord = {16'h0, status.busy, 7'h0, status.rxData};
			default: rdResp = SLVERR;  // unmapped reads return zero
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rvalid <= 1'b0;
		end else if (rdAccept) begin
			rvalid <= 1'b1;
		end else if (axiReq.rready) begin
			rvalid <= 1'b0;
		end
	end

	// read payload, only looked at while rvalid is high
	always_ff @(posedge clk) begin
		if (rdAccept) begin
			rdata <= rdWord;
			rresp <= rdResp;
		end
	end

	always_comb begin
		axiRsp.awready = wrAccept;
		axiRsp.wready  = wrAccept;
		axiRsp.bvalid  = bvalid;
		axiRsp.bresp   = bresp;
		axiRsp.arready = rdAccept;
		axiRsp.rvalid  = rvalid;
		axiRsp.rdata   = rdata;
		axiRsp.rresp   = rresp;
	end

	// a stalled B response keeps its code until the master takes it
	bHoldA: assert property (@(posedge clk) disable iff (!rstN)
		axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid && $stable(axiRsp.bresp));

	// the engine only leaves idle on a command from this block
	busyOnCmdA: assert property (@(posedge clk) disable iff (!rstN)
		$fell(cmdReady) |-> $past(cmdValid));

	// R holds its data while the master stalls
	rHoldA: assert property (@(posedge clk) disable iff (!rstN)
		axiRsp.rvalid && !axiReq.rready |=> axiRsp.rvalid && $stable(axiRsp.rdata));

endmodule

// File: src/spiByteEngine.sv
// SPI mode 0 byte engine for the flash master.
// Each accepted command latches chip select and, when selecting, shifts one full-duplex byte.
`include "spiFlash_settings.svh"

module spiByteEngine (
	input  logic                    clk,
	input  logic                    rstN,
	input  logic                    cfgDone,
	input  spiFlashPkg::spiCmd_t    cmd,
	input  logic                    cmdValid,
	output logic                    cmdReady,
	output spiFlashPkg::spiStatus_t status,
	input  logic                    miso,
	output spiFlashPkg::spiPins_t   spiPins
);
	import spiFlashPkg::*;

	localparam int SckDiv = `SPI_SCK_DIV;
	localparam int DivW = (SckDiv > 1) ? $clog2(SckDiv) : 1;
	localparam int XferCycles = 16 * SckDiv;  // 16 half periods per byte

	logic            busy;
	logic            csLatch;   // 1 keeps the flash deselected
	logic            sck;
	logic [DivW-1:0] divCnt;    // clk cycles within a half period
	logic [3:0]      halfCnt;   // half period index, 0 to 15
	logic [7:0]      shiftReg;  // tx byte going out the top, rx byte coming in the bottom
	logic            misoBit;   // MISO held from the rising edge until the next falling edge
	logic            take;
	logic            start;
	logic            halfEnd;
	logic            sckRise;
	logic            sckFall;

	assign take = cmdValid & cmdReady;
	// no transfer starts until the flash reports ready
	assign start = take & ~cmd.deselect & cfgDone;

	assign halfEnd = busy && (divCnt == DivW'(SckDiv - 1));
	assign sckRise = halfEnd & ~sck;  // SCK goes 0 to 1 at this edge
	assign sckFall = halfEnd & sck;

	// chip select holds until the next command
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			csLatch <= 1'b1;
		end else if (take) begin
			csLatch <= cmd.deselect | ~cfgDone;  // a select before cfgDone is ignored
		end
	end

	// SCK generation and byte length
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy    <= 1'b0;
			sck     <= 1'b0;
			divCnt  <= '0;
			halfCnt <= '0;
		end else if (start) begin
			busy    <= 1'b1;
			sck     <= 1'b0;  // idle low, first edge is rising
			divCnt  <= '0;
			halfCnt <= '0;
		end else if (busy) begin
			if (halfEnd) begin
				divCnt  <= '0;
				halfCnt <= halfCnt + 4'd1;
				sck     <= ~sck;
				if (halfCnt == 4'd15) begin
					busy <= 1'b0;  // eighth falling edge ends the byte
				end
			end else begin
				divCnt <= divCnt + DivW'(1);
			end
		end
	end

	// sample on rising SCK, the slave shifts on falling SCK
	always_ff @(posedge clk) begin
		if (sckRise) begin
			misoBit <= miso;
		end
	end

	// circular shift on falling SCK
	// MSB leaves on MOSI while the sampled MISO bit enters at the LSB
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			shiftReg <= '0;
		end else if (start) begin
			shiftReg <= cmd.data;
		end else if (sckFall) begin
			shiftReg <= {shiftReg[6:0], misoBit};
		end
	end

	assign cmdReady = ~busy;
	assign status.busy = busy;
	assign status.rxData = shiftReg;  // full rx byte once busy falls

	assign spiPins.sck = sck;
	assign spiPins.csN = csLatch | ~cfgDone;  // flash not ready, keep it deselected
	assign spiPins.mosi = busy & shiftReg[7];  // bit 7 is on the line before the first rise

	// clock pulses only reach a selected flash
	csDuringSckA: assert property (@(posedge clk) disable iff (!rstN)
		spiPins.sck && cfgDone |-> !spiPins.csN);

	// one byte is always exactly 16 half periods long
	busyLenA: assert property (@(posedge clk) disable iff (!rstN)
		$fell(busy) |-> $past(busy, XferCycles) && !$past(busy, XferCycles + 1));

	// SCK idles low between bytes
	sckIdleA: assert property (@(posedge clk) disable iff (!rstN)
		!busy |-> !sck);

endmodule

// File: src/spiFlashCtrl.sv
// Top level of the memory-mapped SPI flash master.
// The AXI4-Lite register block feeds byte commands to the SPI byte engine.

module spiFlashCtrl (
	input  logic                     clk,
	input  logic                     rstN,
	input  logic                     cfgDone,   // flash configured and ready
	input  spiFlashPkg::axiLiteReq_t axiReq,
	output spiFlashPkg::axiLiteRsp_t axiRsp,
	input  logic                     miso,
	output spiFlashPkg::spiPins_t    spiPins
);
	import spiFlashPkg::*;

	spiCmd_t    cmd;       // byte command toward the engine
	logic       cmdValid;
	logic       cmdReady;  // engine idle
	spiStatus_t status;    // busy and last rx byte

	// register map and AXI handshakes
	axiLiteSpiRegs axiLiteSpiRegs_i (
		.clk      (clk),
		.rstN     (rstN),
		.axiReq   (axiReq),
		.axiRsp   (axiRsp),
		.cmd      (cmd),
		.cmdValid (cmdValid),
		.cmdReady (cmdReady),
		.status   (status)
	);

	// pin timing and shifting
	spiByteEngine spiByteEngine_i (
		.clk      (clk),
		.rstN     (rstN),
		.cfgDone  (cfgDone),
		.cmd      (cmd),
		.cmdValid (cmdValid),
		.cmdReady (cmdReady),
		.status   (status),
		.miso     (miso),
		.spiPins  (spiPins)
	);

endmodule

// File: src/spiFlashPkg.sv
// Shared types for the SPI flash master.
// Holds the AXI4-Lite channel bundles and the command, status and pin bundles.
`include "spiFlash_settings.svh"

package spiFlashPkg;

	// AXI response codes, only the two the register block ever returns
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axiResp_t;

	// master to slave
	typedef struct packed {
		logic                   awvalid;
		logic [`SPI_ADDR_W-1:0] awaddr;
		logic                   wvalid;
		logic [31:0]            wdata;
		logic [3:0]             wstrb;  // lane 0 is the byte, lane 1 carries the deselect bit
		logic                   bready;
		logic                   arvalid;
		logic [`SPI_ADDR_W-1:0] araddr;
		logic                   rready;
	} axiLiteReq_t;

	// slave to master
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		axiResp_t    bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		axiResp_t    rresp;
	} axiLiteRsp_t;

	// one byte command, same layout as bits 8:0 of the data register
	typedef struct packed {
		logic       deselect;  // 1 raises csN and sends nothing
		logic [7:0] data;      // byte shifted out MSB first
	} spiCmd_t;

	// engine state seen through the status register
	typedef struct packed {
		logic       busy;
		logic [7:0] rxData;
	} spiStatus_t;

	// outgoing flash pins
	typedef struct packed {
		logic sck;
		logic csN;
		logic mosi;
	} spiPins_t;

endpackage

// File: src/spiFlash_settings.svh
// Build-time settings for the SPI flash master.
// Include this header wherever the bus width, register map or SCK rate is needed.
`ifndef SPI_FLASH_SETTINGS_SVH
`define SPI_FLASH_SETTINGS_SVH

// AXI4-Lite address width in bits
`define SPI_ADDR_W 4

// register map, byte offsets on the AXI4-Lite bus
`define SPI_REG_DATA 'h0    // write starts a byte, read returns last command
`define SPI_REG_STATUS 'h4  // busy in bit 15, rx byte in bits 7:0

// clk cycles per SCK half period
// one byte takes 16 half periods, so 16 * SPI_SCK_DIV clk cycles
// any value of 1 or more works
`define SPI_SCK_DIV 2

`endif

// File: tests/flashModel.sv
// Behavioral SPI NOR flash stand-in, mode 0.
// Answers 0x5A as the first byte after select, then the complement of each byte it received.
module flashModel (
	input  spiFlashPkg::spiPins_t pins,
	output logic                  miso,
	output logic [7:0]            lastRx,   // last full byte seen on MOSI
	output int                    rxCount   // bytes received since time 0
);
	timeunit 1ns;
	timeprecision 100ps;

	logic       sck;
	logic       csN;
	logic       mosi;
	logic [7:0] txShift;  // answer byte, MSB on MISO
	logic [7:0] rxShift;
	logic [2:0] bitCnt;
	logic       reload;   // next falling edge starts a new answer byte

	assign sck = pins.sck;
	assign csN = pins.csN;
	assign mosi = pins.mosi;

	initial begin
		miso = 1'b0;
		lastRx = 8'h00;
		rxCount = 0;
		txShift = 8'h00;
		rxShift = 8'h00;
		bitCnt = 3'd0;
		reload = 1'b0;
	end

	// new select window, first answer is fixed
	always @(negedge csN) begin
		txShift = 8'h5A;
		bitCnt = 3'd0;
		reload = 1'b0;
		miso = txShift[7];  // bit 7 waits for the first rising edge
	end

	always @(posedge csN) begin
		bitCnt = 3'd0;
		reload = 1'b0;
		miso = 1'b0;
	end

	// master data is stable on the rising edge
	always @(posedge sck) begin
		if (!csN) begin
			rxShift = {rxShift[6:0], mosi};
			if (bitCnt == 3'd7) begin
				lastRx = rxShift;
				rxCount++;
				reload = 1'b1;
				bitCnt = 3'd0;
			end else begin
				bitCnt = bitCnt + 3'd1;
			end
		end
	end

	always @(negedge sck) begin
		if (!csN) begin
			if (reload) begin
				txShift = ~lastRx;  // answer to the byte just taken
				reload = 1'b0;
			end else begin
				txShift = {txShift[6:0], 1'b0};
			end
			miso = txShift[7];
		end
	end

endmodule

// File: tests/tbClock.sv
// Clock and reset source for the SPI flash testbench.
// Reset is released on a falling edge after the given number of cycles.
module tbClock #(
	parameter int PeriodNs = 4,
	parameter int ResetCycles = 2
) (
	output logic clk,
	output logic rstN
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PeriodNs / 2) clk = ~clk;
	end

	initial begin
		rstN = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);  // release away from the active edge
		rstN = 1'b1;
	end

endmodule

// File: tests/tbSpiFlashCtrl.sv
// Testbench for the SPI flash master.
// AXI4-Lite tasks send byte commands, a flash model answers on MISO,
// and a compare process checks each status read and bus response.
`include "spiFlash_settings.svh"

module tbSpiFlashCtrl;
	timeunit 1ns;
	timeprecision 100ps;
	import spiFlashPkg::*;

	localparam int ClkNs = 4;
	localparam int NumBytes = 13;  // transfers over all tests
	localparam int ByteNs = 16 * `SPI_SCK_DIV * ClkNs;
	localparam int MarginNs = 3000;  // AXI handshakes and polling
	localparam logic [`SPI_ADDR_W-1:0] AddrData = `SPI_ADDR_W'(`SPI_REG_DATA);
	localparam logic [`SPI_ADDR_W-1:0] AddrStatus = `SPI_ADDR_W'(`SPI_REG_STATUS);
	localparam logic [`SPI_ADDR_W-1:0] AddrBad = `SPI_ADDR_W'('h8);  // unmapped

	logic        clk;
	logic        rstN;
	logic        cfgDone;
	logic        miso;
	axiLiteReq_t axiReq;
	axiLiteRsp_t axiRsp;
	spiPins_t    spiPins;
	logic [7:0]  modelRx;     // last byte the flash saw on MOSI
	int          modelCount;

	logic [15:0] lfsr = 16'd52120;
	int          errors = 0;
	int          testsPassed = 0;
	int          testsFailed = 0;
	int          errMark;     // error count when the test began
	string       testName;
	logic [7:0]  prevSent;    // byte shifted out just before
	logic        firstInWindow;
	logic [7:0]  rxExp;       // rx byte the status register should hold
	spiCmd_t     cmdSent;     // last data register write
	spiStatus_t  gotStatusQ[$];
	spiStatus_t  expStatusQ[$];
	axiResp_t    gotRespQ[$];
	axiResp_t    expRespQ[$];

	tbClock #(.PeriodNs(ClkNs), .ResetCycles(2)) tbClock_i (.clk(clk), .rstN(rstN));

	spiFlashCtrl spiFlashCtrl_i (
		.clk     (clk),
		.rstN    (rstN),
		.cfgDone (cfgDone),
		.axiReq  (axiReq),
		.axiRsp  (axiRsp),
		.miso    (miso),
		.spiPins (spiPins)
	);

	flashModel flashModel_i (.pins(spiPins), .miso(miso), .lastRx(modelRx), .rxCount(modelCount));

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsrStep();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] randByte();
		logic [7:0] b;
		b = 8'h00;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsrStep()};  // one step per bit
		end
		return b;
	endfunction

	// flash answer rule, 0x5A opens a window, then the complement of the previous byte
	function automatic logic [7:0] expectedRx(input logic first, input logic [7:0] prev);
		if (first) begin
			return 8'h5A;
		end else begin
			return ~prev;
		end
	endfunction

	function automatic spiStatus_t idleStatus(input logic [7:0] rx);
		spiStatus_t s;
		s.busy = 1'b0;
		s.rxData = rx;
		return s;
	endfunction

	task automatic checkStatus(input spiStatus_t got, input spiStatus_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s status busy=%0b rx=0x%02h, expected busy=%0b rx=0x%02h",
				$time, testName, got.busy, got.rxData, exp.busy, exp.rxData);
			errors++;
		end
	endtask

	task automatic checkResp(input axiResp_t got, input axiResp_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s response %s, expected %s",
				$time, testName, got.name(), exp.name());
			errors++;
		end
	endtask

	task automatic checkCmd(input spiCmd_t got, input spiCmd_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s data reg readback 0x%03h, expected 0x%03h",
				$time, testName, got, exp);
			errors++;
		end
	endtask

	task automatic checkByte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s %s 0x%02h, expected 0x%02h",
				$time, testName, what, got, exp);
			errors++;
		end
	endtask

	task automatic checkPins(input spiPins_t got, input logic csN);
		if (got !== {1'b0, csN, 1'b0}) begin  // sck and mosi idle low
			$display("[ERROR] %0t ns: %s pins sck=%0b csN=%0b mosi=%0b, expected csN=%0b idle",
				$time, testName, got.sck, got.csN, got.mosi, csN);
			errors++;
		end
	endtask

	task automatic checkNoTransfer(input int countBefore);
		if (modelCount != countBefore) begin
			$display("%0t ns: %s the flash received a byte although nothing was sent",
				$time, testName);
			errors++;
		end
	endtask

	// all compares happen here, the stimulus only queues results
	initial begin
		forever begin
			@(posedge clk);
			while (gotStatusQ.size() > 0) begin
				checkStatus(gotStatusQ.pop_front(), expStatusQ.pop_front());
			end
			while (gotRespQ.size() > 0) begin
				checkResp(gotRespQ.pop_front(), expRespQ.pop_front());
			end
		end
	end

	task automatic expectResp(input axiResp_t got, input axiResp_t exp);
		gotRespQ.push_back(got);
		expRespQ.push_back(exp);
	endtask

	task automatic axiWrite(input logic [`SPI_ADDR_W-1:0] addr, input logic [31:0] data,
			output axiResp_t resp, output int stall);
		stall = 0;
		@(negedge clk);
		axiReq.awvalid = 1'b1;
		axiReq.awaddr = addr;
		axiReq.wvalid = 1'b1;
		axiReq.wdata = data;
		axiReq.wstrb = 4'hF;
		axiReq.bready = 1'b1;
		@(posedge clk);
		while (!axiRsp.awready && !axiRsp.wready) begin
			stall++;  // held off by a busy engine
			@(posedge clk);
		end
		if (axiRsp.awready !== axiRsp.wready) begin
			$display("[ERROR] %0t ns: %s AW and W accepted apart, awready=%0b wready=%0b",
				$time, testName, axiRsp.awready, axiRsp.wready);
			errors++;
		end
		@(negedge clk);
		axiReq.awvalid = 1'b0;
		axiReq.wvalid = 1'b0;
		@(posedge clk);
		while (!axiRsp.bvalid) @(posedge clk);
		resp = axiRsp.bresp;
		@(negedge clk);
		axiReq.bready = 1'b0;
	endtask

	task automatic axiRead(input logic [`SPI_ADDR_W-1:0] addr, output logic [31:0] data,
			output axiResp_t resp);
		@(negedge clk);
		axiReq.arvalid = 1'b1;
		axiReq.araddr = addr;
		axiReq.rready = 1'b1;
		@(posedge clk);
		while (!axiRsp.arready) @(posedge clk);
		@(negedge clk);
		axiReq.arvalid = 1'b0;
		@(posedge clk);
		while (!axiRsp.rvalid) @(posedge clk);
		data = axiRsp.rdata;
		resp = axiRsp.rresp;
		@(negedge clk);
		axiReq.rready = 1'b0;
	endtask

	task automatic readStatus(output spiStatus_t st, output axiResp_t resp);
		logic [31:0] word;
		axiRead(AddrStatus, word, resp);
		st.busy = word[15];
		st.rxData = word[7:0];
	endtask

	task automatic sendByte(input logic [7:0] b, input logic deselect, output int stall);
		axiResp_t resp;
		axiWrite(AddrData, {23'h0, deselect, b}, resp, stall);
		expectResp(resp, OKAY);
		cmdSent.deselect = deselect;
		cmdSent.data = b;
	endtask

	task automatic noteSent(input logic [7:0] b);
		prevSent = b;
		firstInWindow = 1'b0;
	endtask

	// poll until the byte ends, then check the rx byte and what the flash got
	task automatic checkAfterByte(input logic [7:0] b);
		spiStatus_t st;
		axiResp_t   resp;
		readStatus(st, resp);
		while (st.busy) begin
			readStatus(st, resp);
		end
		expectResp(resp, OKAY);
		rxExp = expectedRx(firstInWindow, prevSent);
		gotStatusQ.push_back(st);
		expStatusQ.push_back(idleStatus(rxExp));
		checkByte(modelRx, b, "MOSI byte at flash");
		noteSent(b);
	endtask

	task automatic checkIdle();
		spiStatus_t st;
		axiResp_t   resp;
		readStatus(st, resp);
		expectResp(resp, OKAY);
		gotStatusQ.push_back(st);
		expStatusQ.push_back(idleStatus(rxExp));
	endtask

	task automatic startTest(input string name);
		testName = name;
		errMark = errors;
	endtask

	task automatic finishTest();
		while (gotStatusQ.size() > 0 || gotRespQ.size() > 0) @(negedge clk);
		if (errors == errMark) begin
			testsPassed++;
			$display("test %s: ok", testName);
		end else begin
			testsFailed++;
			$display("test %s: %0d errors", testName, errors - errMark);
		end
	endtask

	initial begin
		axiResp_t    resp;
		logic [31:0] word;
		int          stall;
		int          countBefore;
		logic [7:0]  b0;
		logic [7:0]  b1;
		axiReq = '0;
		cfgDone = 1'b0;
		prevSent = 8'h00;
		firstInWindow = 1'b1;
		rxExp = 8'h00;  // shift register clears on reset
		cmdSent = '0;
		wait (rstN === 1'b1);

		startTest("reset and cfgDone gate");
		checkIdle();
		countBefore = modelCount;
		b0 = randByte();
		sendByte(b0, 1'b0, stall);  // select and send, flash not ready yet
		checkIdle();
		checkPins(spiPins, 1'b1);
		checkNoTransfer(countBefore);
		@(negedge clk);
		cfgDone = 1'b1;
		sendByte(b0, 1'b0, stall);
		checkAfterByte(b0);
		checkPins(spiPins, 1'b0);
		sendByte(8'h00, 1'b1, stall);  // close the window for the next test
		firstInWindow = 1'b1;
		finishTest();

		startTest("single byte");
		b0 = randByte();
		sendByte(b0, 1'b0, stall);
		checkAfterByte(b0);
		checkPins(spiPins, 1'b0);
		finishTest();

		startTest("burst in one window");
		for (int k = 0; k < 5; k++) begin
			b0 = randByte();
			b1 = randByte();
			sendByte(b0, 1'b0, stall);
			noteSent(b0);
			sendByte(b1, 1'b0, stall);  // lands while b0 is still shifting
			if (stall == 0) begin
				$display("%0t ns: %s a write during a busy byte was taken without waiting",
					$time, testName);
				errors++;
			end
			checkByte(modelRx, b0, "MOSI byte at flash");
			checkAfterByte(b1);
		end
		finishTest();

		startTest("deselect");
		countBefore = modelCount;
		sendByte(8'h00, 1'b1, stall);
		checkIdle();
		checkPins(spiPins, 1'b1);
		checkNoTransfer(countBefore);
		firstInWindow = 1'b1;
		b0 = randByte();
		sendByte(b0, 1'b0, stall);
		checkAfterByte(b0);
		finishTest();

		startTest("register errors");
		countBefore = modelCount;
		axiWrite(AddrStatus, 32'h0000_00A5, resp, stall);  // status is read only
		expectResp(resp, SLVERR);
		axiWrite(AddrBad, 32'h0000_003C, resp, stall);
		expectResp(resp, SLVERR);
		checkIdle();
		checkNoTransfer(countBefore);
		axiRead(AddrData, word, resp);
		expectResp(resp, OKAY);
		checkCmd(spiCmd_t'(word[8:0]), cmdSent);
		finishTest();

		$display("tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errors);
		if (testsFailed == 0 && errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// bound on the whole run, every byte plus bus overhead
	initial begin
		#(NumBytes * ByteNs + MarginNs);
		$display("timeout after %0d ns, the tests did not finish", NumBytes * ByteNs + MarginNs);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+src
src/spiFlashPkg.sv
src/axiLiteSpiRegs.sv
src/spiByteEngine.sv
src/spiFlashCtrl.sv
tests/tbClock.sv
tests/flashModel.sv
tests/tbSpiFlashCtrl.sv
